//--- logic/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data and address word width
`define XLEN 32

// architectural registers, x0 included
`define NR_REGS 32

// wishbone word-address width of the slave port
`define WB_ADR_W 6

`endif

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        op_r     = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [4:0] reg_idx_t;

    // funct3 encodings of the alu instructions
    localparam funct3_t f3_add  = 3'b000; // add, sub, addi
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101; // srl and sra
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    function automatic logic is_supported(opcode_t op);
        return op inside {op_r, op_imm, op_lui, op_auipc, op_jal};
    endfunction

endpackage

//--- logic/exec_bus_pkg.sv
`include "exec_settings.svh"

package exec_bus_pkg;

    typedef logic [`WB_ADR_W-1:0] wb_reg_t;

    // register map of the slave port, in words
    localparam wb_reg_t wb_gpr_last = 6'd31; // x0..x31, read only
    localparam wb_reg_t wb_pc       = 6'd32; // read and write
    localparam wb_reg_t wb_insn     = 6'd33; // write issues one instruction
    localparam wb_reg_t wb_result   = 6'd34; // last alu result, read only

endpackage

//--- logic/key_mux.sv
module key_mux #(
    parameter int  NR_KEY    = 2,
    parameter int  KEY_W     = 4,
    parameter type payload_t = logic
) (
    input  logic [KEY_W-1:0] key,
    input  logic [KEY_W-1:0] keys          [NR_KEY],
    input  payload_t         values        [NR_KEY],
    input  payload_t         default_value,
    output payload_t         out
);

    // walk the table backwards so the first matching entry wins
    always_comb begin
        out = default_value;
        for (int i = NR_KEY - 1; i >= 0; i--) begin
            if (key == keys[i]) begin
                out = values[i];
            end
        end
    end

endmodule

//--- logic/alu.sv
`include "exec_settings.svh"

module alu (
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  rv_isa_pkg::alu_op_t op,
    output logic [`XLEN-1:0]   res
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0]; // only the low 5 bits shift
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            alu_add:    res = a + b;
            alu_sub:    res = a - b;
            alu_sll:    res = a << shamt;
            alu_slt:    res = {{(`XLEN-1){1'b0}}, lt_s};
            alu_sltu:   res = {{(`XLEN-1){1'b0}}, lt_u};
            alu_xor:    res = a ^ b;
            alu_srl:    res = a >> shamt;
            alu_sra:    res = $signed(a) >>> shamt;
            alu_or:     res = a | b;
            alu_and:    res = a & b;
            alu_pass_b: res = b;
            default:    res = '0;
        endcase
    end

endmodule

//--- logic/idu.sv
`include "exec_settings.svh"

module idu (
    input  logic [`XLEN-1:0]    insn,
    output rv_isa_pkg::opcode_t  opcode,
    output rv_isa_pkg::funct3_t  funct3,
    output logic                 funct7_b5,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd,
    output logic [`XLEN-1:0]    imm,
    output logic                 rd_we
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode    = opcode_t'(insn[6:0]);
    assign rd        = insn[11:7];
    assign funct3    = insn[14:12];
    assign rs1       = insn[19:15];
    assign rs2       = insn[24:20];
    assign funct7_b5 = insn[30];

    assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};

    // upper 20 bits only, exu moves them into place
    assign imm_u = {{(`XLEN-20){insn[31]}}, insn[31:12]};

    // byte offset, bit 0 always zero
    assign imm_j = {{(`XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
                    insn[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_imm:   imm = imm_i;
            op_lui:   imm = imm_u;
            op_auipc: imm = imm_u;
            op_jal:   imm = imm_j;
            default:  imm = '0; // r-type has no immediate
        endcase
    end

    // unsupported words and x0 targets write nothing
    assign rd_we = is_supported(opcode) && (rd != 5'd0);

endmodule

//--- logic/exu.sv
`include "exec_settings.svh"

module exu (
    input  logic [`XLEN-1:0]   pc,
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_isa_pkg::funct3_t funct3,
    input  logic                funct7_b5,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`XLEN-1:0]   rs1_value,
    input  logic [`XLEN-1:0]   rs2_value,
    output logic [`XLEN-1:0]   result,
    output logic                is_jump
);
    import rv_isa_pkg::*;

    localparam logic [6:0] opnd_keys [5] = '{op_r, op_imm, op_lui, op_auipc, op_jal};

    // {alu type, funct7 bit 5, funct3}
    localparam logic [4:0] op_keys [10] = '{
        {2'b10, f3_add}, {2'b11, f3_add}, {2'b10, f3_sll}, {2'b10, f3_slt},
        {2'b10, f3_sltu}, {2'b10, f3_xor}, {2'b10, f3_sr}, {2'b11, f3_sr},
        {2'b10, f3_or}, {2'b10, f3_and}
    };
    localparam alu_op_t op_values [10] = '{
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    };

    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] a_values [5];
    logic [`XLEN-1:0] b_values [5];
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic             is_alu;
    logic             sel_b5;
    logic [4:0]       op_key;
    alu_op_t          op_default;
    alu_op_t          op;

    assign imm_u    = {imm[19:0], 12'b0};
    assign a_values = '{rs1_value, rs1_value, '0, pc, pc};
    assign b_values = '{rs2_value, imm, imm_u, imm_u, imm};

    // bit 30 is an immediate bit for every op-imm except the right shifts
    assign is_alu     = (opcode == op_r) || (opcode == op_imm);
    assign sel_b5     = funct7_b5 & ((opcode == op_r) || (funct3 == f3_sr));
    assign op_key     = {is_alu, sel_b5, funct3};
    assign op_default = (opcode == op_lui) ? alu_pass_b : alu_add; // jal, auipc add
    assign is_jump    = opcode == op_jal;

    key_mux #(.NR_KEY(5), .KEY_W(7), .payload_t(logic [`XLEN-1:0])) a_mux (
        .key(opcode), .keys(opnd_keys), .values(a_values),
        .default_value('0), .out(op_a)
    );

    key_mux #(.NR_KEY(5), .KEY_W(7), .payload_t(logic [`XLEN-1:0])) b_mux (
        .key(opcode), .keys(opnd_keys), .values(b_values),
        .default_value('0), .out(op_b)
    );

    key_mux #(.NR_KEY(10), .KEY_W(5), .payload_t(alu_op_t)) op_mux (
        .key(op_key), .keys(op_keys), .values(op_values),
        .default_value(op_default), .out(op)
    );

    alu alu_i (
        .a  (op_a),
        .b  (op_b),
        .op (op),
        .res(result)
    );

endmodule

//--- logic/reg_file.sv
`include "exec_settings.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output logic [`XLEN-1:0]    rs1_value,
    output logic [`XLEN-1:0]    rs2_value,
    input  rv_isa_pkg::reg_idx_t rd,
    input  logic [`XLEN-1:0]    rd_data,
    input  logic                 rd_we,
    input  rv_isa_pkg::reg_idx_t dbg_idx,
    output logic [`XLEN-1:0]    dbg_value
);

    logic [`XLEN-1:0] regs [`NR_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 reads zero whatever the array holds
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbg_value = (dbg_idx == 5'd0) ? '0 : regs[dbg_idx]; // host read port

endmodule

//--- logic/exec_core.sv
`include "exec_settings.svh"

module exec_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`XLEN-1:0]     wb_dat_w,
    output logic [`XLEN-1:0]     wb_dat_r,
    output logic                 wb_ack
);
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;

    localparam logic [`XLEN-1:0] insn_bytes = 4;

    logic             req;
    logic             pend;
    logic             we_q;
    wb_reg_t          adr_q;
    logic [`XLEN-1:0] wdata_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] result_q;
    logic [`XLEN-1:0] pc_inc;
    logic [`XLEN-1:0] wb_data;
    logic [`XLEN-1:0] rd_mux;
    logic             commit;
    logic             pc_wr;

    opcode_t          opcode;
    funct3_t          funct3;
    logic             funct7_b5;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    reg_idx_t         rd;
    logic [`XLEN-1:0] imm;
    logic             rd_we;
    logic [`XLEN-1:0] rs1_value;
    logic [`XLEN-1:0] rs2_value;
    logic [`XLEN-1:0] dbg_value;
    logic [`XLEN-1:0] result;
    logic             is_jump;

    // a new request only while no transfer is in flight or acked
    assign req     = wb_cyc & wb_stb & ~pend & ~wb_ack;
    assign commit  = pend & we_q & (adr_q == wb_insn) & is_supported(opcode);
    assign pc_wr   = pend & we_q & (adr_q == wb_pc);
    assign pc_inc  = pc_q + insn_bytes;
    assign wb_data = is_jump ? pc_inc : result; // jal links the return address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            we_q     <= 1'b0;
            wb_ack   <= 1'b0;
            pc_q     <= '0;
            result_q <= '0;
        end else begin
            pend   <= req;
            wb_ack <= pend; // one cycle after the request was seen
            if (req) begin
                we_q <= wb_we;
            end
            if (pc_wr) begin
                pc_q <= wdata_q;
            end else if (commit) begin
                pc_q <= is_jump ? result : pc_inc;
            end
            if (commit) begin
                result_q <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            adr_q   <= wb_adr;
            wdata_q <= wb_dat_w; // insn word or new pc
        end
        if (pend && !we_q) begin
            wb_dat_r <= rd_mux;
        end
    end

    always_comb begin
        if (adr_q <= wb_gpr_last) begin
            rd_mux = dbg_value;
        end else if (adr_q == wb_pc) begin
            rd_mux = pc_q;
        end else if (adr_q == wb_result) begin
            rd_mux = result_q;
        end else begin
            rd_mux = '0; // insn and unmapped words read zero
        end
    end

    idu idu_i (
        .insn     (wdata_q),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_b5(funct7_b5),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .rd_we    (rd_we)
    );

    exu exu_i (
        .pc       (pc_q),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_b5(funct7_b5),
        .imm      (imm),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .result   (result),
        .is_jump  (is_jump)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .rd       (rd),
        .rd_data  (wb_data),
        .rd_we    (commit & rd_we),
        .dbg_idx  (reg_idx_t'(adr_q[4:0])),
        .dbg_value(dbg_value)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk; // free running

endmodule

//--- test/exec_core_sva.sv
`include "exec_settings.svh"

module exec_core_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input logic [`WB_ADR_W-1:0] wb_adr,
    input logic [`XLEN-1:0]     wb_dat_r,
    input logic                 wb_ack,
    input logic                 req
);

    bit failed; // sticky, polled by the testbench top

    ack_low_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_ack)
        else begin $error("ack high while in reset"); failed = 1'b1; end

    ack_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_ack)
        else begin $error("ack high right after reset"); failed = 1'b1; end

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req |=> !wb_ack ##1 wb_ack)
        else begin $error("ack did not follow the request by one cycle"); failed = 1'b1; end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin $error("ack lasted more than one cycle"); failed = 1'b1; end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb && $past(req, 2))
        else begin $error("ack without a request"); failed = 1'b1; end

    // x0 on the host read port
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_ack && !wb_we && wb_adr == 6'd0) |-> wb_dat_r == '0)
        else begin $error("x0 read back nonzero"); failed = 1'b1; end

endmodule

//--- test/exec_core_tb.sv
`include "exec_settings.svh"

module exec_core_tb;
    import exec_bus_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [`XLEN-1:0]     wb_dat_w;
    logic [`XLEN-1:0]     wb_dat_r;
    logic                 wb_ack;
    logic [`XLEN-1:0]     regs_m [`NR_REGS]; // reference register file
    logic [`XLEN-1:0]     pc_m;
    logic [`XLEN-1:0]     res_m;
    int                   cycles;

    tb_clock #(.PERIOD(100)) clk_gen (.clk(clk));

    exec_core UUT (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    bind exec_core exec_core_sva sva_i (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .req(req)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (UUT.sva_i.failed) begin
            $display("a bus protocol assertion failed");
            $display("tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] alu_ref(int f3, logic alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(int alt, int rs2, int rs1, int f3, int rd);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] enc_u(logic [31:0] imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // reference model of one instruction, from the ISA rules
    task automatic model_exec(logic [31:0] insn);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [31:0] r;
        logic        ok;
        opc = insn[6:0];
        rd  = insn[11:7];
        ok  = 1'b1;
        r   = '0;
        case (opc)
            7'h33: r = alu_ref(int'(insn[14:12]), insn[30], regs_m[insn[19:15]],
                               regs_m[insn[24:20]]);
            7'h13: r = alu_ref(int'(insn[14:12]), insn[30] && insn[14:12] == 3'd5,
                               regs_m[insn[19:15]], {{20{insn[31]}}, insn[31:20]});
            7'h37: r = {insn[31:12], 12'b0};
            7'h17: r = pc_m + {insn[31:12], 12'b0};
            7'h6f: r = pc_m + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            default: ok = 1'b0;
        endcase
        if (ok) begin
            if (rd != 5'd0) regs_m[rd] = (opc == 7'h6f) ? pc_m + 4 : r;
            pc_m  = (opc == 7'h6f) ? r : pc_m + 4;
            res_m = r;
        end
    endtask

    task automatic bus_xfer(logic we, int adr, logic [31:0] wdata, output logic [31:0] rdata);
        int   gap;
        logic keep_cyc;
        gap      = $urandom_range(0, 2);
        keep_cyc = $urandom_range(0, 3) == 0;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr[5:0];
        wb_dat_w <= wdata;
        do @(negedge clk); while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk); // stb is still seen high at this edge
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!keep_cyc) wb_cyc <= 1'b0;
    endtask

    task automatic check_read(int adr, logic [31:0] exp, string name);
        logic [31:0] got;
        bus_xfer(1'b0, adr, '0, got);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_reg(int idx);
        check_read(idx, regs_m[idx], $sformatf("x%0d", idx));
    endtask

    task automatic issue(logic [31:0] insn);
        logic [31:0] unused;
        bus_xfer(1'b1, int'(wb_insn), insn, unused);
        model_exec(insn);
    endtask

    task automatic check_pc_result();
        check_read(int'(wb_pc), pc_m, "pc");
        check_read(int'(wb_result), res_m, "result");
    endtask

    initial begin
        logic [31:0] imm;
        logic [31:0] unused;
        int          rd;
        void'($urandom(35));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cycles   = 0;
        pc_m     = '0;
        res_m    = '0;
        for (int i = 0; i < 32; i++) regs_m[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        check_pc_result();
        for (int i = 0; i < 32; i++) check_reg(i);

        for (int i = 1; i < 32; i++) begin // lui then addi fills each register
            issue(enc_u($urandom(), i, 7'h37));
            issue(enc_i($urandom(), i, 0, i));
        end

        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f != 0 && f != 5) continue;
                repeat (4) begin
                    rd = $urandom_range(1, 31);
                    issue(enc_r(alt, $urandom_range(0, 31), $urandom_range(0, 31), f, rd));
                    check_reg(rd);
                end
                check_read(int'(wb_result), res_m, "result");
            end
        end

        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f != 5) continue;
                repeat (3) begin
                    imm = $urandom();
                    if (f == 1 || f == 5) imm = {20'b0, 1'b0, alt[0], 5'b0, imm[4:0]};
                    rd = $urandom_range(1, 31);
                    issue(enc_i(imm, $urandom_range(0, 31), f, rd));
                    check_reg(rd);
                end
            end
        end
        issue(enc_i($urandom(), $urandom_range(1, 31), 0, 0)); // addi to x0
        check_reg(0);

        repeat (6) begin
            bus_xfer(1'b1, int'(wb_pc), $urandom() & 32'hffff_fffc, unused);
            pc_m = wb_dat_w;
            rd = $urandom_range(1, 31);
            issue(enc_u($urandom(), rd, 7'h17));
            check_reg(rd);
            check_pc_result();
            rd = $urandom_range(1, 31);
            issue(enc_j($urandom(), rd));
            check_reg(rd);
            check_pc_result();
        end

        issue(32'h0000_0f80); // no supported opcode, nothing changes
        check_pc_result();
        for (int i = 0; i < 32; i++) check_reg(i);

        @(negedge clk);
        if (UUT.sva_i.failed) begin
            $display("tests failed");
            $fatal(1);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/exec_bus_pkg.sv
logic/key_mux.sv
logic/alu.sv
logic/idu.sv
logic/exu.sv
logic/reg_file.sv
logic/exec_core.sv
test/tb_clock.sv
test/exec_core_sva.sv
test/exec_core_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module exec_core_tb -f verilog.f -o sim_exec

run: compile
	-./obj_dir/sim_exec +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
